/* source/chitchat_pkg.sv */
`default_nettype none

package chitchat_pkg;

   // --------------------------------------------------
   // Vector types
   // --------------------------------------------------

   typedef logic [15:0] word_t;          // One transceiver word
   typedef logic [31:0] data_t;          // Payload or revision word
   typedef logic [2:0]  location_t;      // Transmitter ID
   typedef logic [15:0] frame_count_t;   // Frame counter

   // --------------------------------------------------
   // Protocol constants
   // --------------------------------------------------

   // K28.5 in the low byte of word 0
   localparam logic [7:0] CC_K28_5 = 8'hBC;

   // Upper byte of the comma word
   localparam logic [3:0] CC_PROTOCOL_CAT = 4'd1;
   localparam logic [3:0] CC_PROTOCOL_VER = 4'd1;

   // Top bits of word 1
   localparam logic [2:0] CC_GATEWARE_TYPE = 3'd2;

   // Comma, ID, rev ID x2, data0 x2, data1 x2, counters x2, CRC
   localparam int CC_FRAME_WORDS = 11;

   // CRC-16-CCITT, MSB first
   localparam word_t CC_CRC_INIT = 16'h0000;
   localparam word_t CC_CRC_POLY = 16'h1021;   // x^16 + x^12 + x^5 + 1

endpackage

`default_nettype wire

/* source/crc16.sv */
`timescale 1ns/100ps
`default_nettype none

module crc16 (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire chitchat_pkg::word_t din,    // Word folded this cycle
   input  wire                      zero,   // Load init value instead of folding
   output chitchat_pkg::word_t      crc     // Registered remainder
);

   import chitchat_pkg::*;

   // One word through the LFSR, 16 serial steps unrolled
   function automatic word_t crc_fold(input word_t c_in, input word_t d);
      word_t c;
      logic  fb;
      c = c_in;
      for (int i = $bits(word_t) - 1; i >= 0; i--) begin
         fb = c[15] ^ d[i];                          // MSB first
         c  = {c[14:0], 1'b0} ^ (fb ? CC_CRC_POLY : '0);
      end
      return c;
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         crc <= CC_CRC_INIT;
      end else if (zero) begin
         crc <= CC_CRC_INIT;                 // Start of a new frame
      end else begin
         crc <= crc_fold(crc, din);
      end
   end

endmodule

`default_nettype wire

/* source/chitchat_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module chitchat_tx #(
   parameter chitchat_pkg::data_t REV_ID = '0   // Sent in words 2 and 3
) (
   input  wire                             clk,
   input  wire                             arst_n,
   input  wire                             tx_transmit_en,  // Keeps frames flowing
   input  wire chitchat_pkg::location_t    tx_location,
   input  wire chitchat_pkg::data_t        tx_data0,
   input  wire chitchat_pkg::data_t        tx_data1,
   input  wire chitchat_pkg::frame_count_t tx_loopback_frame_counter,
   output logic                            tx_ready,        // Inputs sampled next cycle
   output chitchat_pkg::frame_count_t      local_frame_counter,
   output chitchat_pkg::word_t             gtx_d,
   output logic                            gtx_k            // Comma in low byte
);

   import chitchat_pkg::*;

   localparam logic [3:0] LAST_WORD  = 4'(CC_FRAME_WORDS - 1);
   localparam int         WORD_BITS  = $bits(word_t);
   localparam int         FRAME_BITS = CC_FRAME_WORDS * WORD_BITS;

   // --------------------------------------------------
   // Timing generator
   // --------------------------------------------------

   logic [3:0] word_cnt;     // Position within the 11-cycle frame slot
   logic       running;
   logic       load;         // Parallel load of the shift register
   logic       sync;         // Word 0 at the shift register head
   logic       last;
   logic       last_d1;
   logic       last_d2;
   logic       crc_time;     // Word 10 at the shift register head

   // Keep counting once a frame has begun
   assign running = tx_transmit_en || (word_cnt != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         word_cnt <= '0;
         tx_ready <= 1'b0;
         load     <= 1'b0;
         sync     <= 1'b0;
         gtx_k    <= 1'b0;
         last     <= 1'b0;
         last_d1  <= 1'b0;
         last_d2  <= 1'b0;
         crc_time <= 1'b0;
      end else begin
         word_cnt <= (word_cnt == LAST_WORD) ? '0 : word_cnt + {3'b000, running};
         tx_ready <= (word_cnt == 4'd1);
         load     <= tx_ready;                  // One cycle after the ready pulse
         sync     <= load;
         gtx_k    <= sync;                      // Aligned with word 0 on gtx_d
         last     <= (word_cnt == LAST_WORD);
         last_d1  <= last;
         last_d2  <= last_d1;
         crc_time <= last_d2;
      end
   end

   // --------------------------------------------------
   // Frame shift register
   // --------------------------------------------------

   logic [FRAME_BITS-1:0] frame_q;
   word_t                 frame_head;
   word_t                 crc_tx;

   assign frame_head = frame_q[FRAME_BITS-1 -: WORD_BITS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         local_frame_counter <= '0;
         frame_q             <= '0;             // Idle stream is all zero
      end else begin
         local_frame_counter <= local_frame_counter + frame_count_t'(tx_ready);
         if (load) begin
            // Big-endian 32-bit fields, CRC slot padded with zero
            frame_q <= {CC_PROTOCOL_CAT, CC_PROTOCOL_VER, CC_K28_5,
                        CC_GATEWARE_TYPE, tx_location, 10'b0,
                        REV_ID,
                        tx_data0,
                        tx_data1,
                        local_frame_counter,
                        tx_loopback_frame_counter,
                        16'h0000};
         end else begin
            frame_q <= {frame_q[FRAME_BITS-WORD_BITS-1:0], 16'h0000};  // Zero fill
         end
      end
   end

   // --------------------------------------------------
   // CRC insertion
   // --------------------------------------------------

   // Cleared on word 0, so the remainder covers words 1 to 9
   crc16 crc_i (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (frame_head),
      .zero   (sync),
      .crc    (crc_tx)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gtx_d <= '0;
      end else begin
         gtx_d <= crc_time ? crc_tx : frame_head;   // CRC replaces the pad
      end
   end

endmodule

`default_nettype wire

/* source/chitchat_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module chitchat_rx #(
   parameter int LINK_UP_CNT = 3   // Good frames in a row before link up
) (
   input  wire                        clk,
   input  wire                        arst_n,
   input  wire chitchat_pkg::word_t   gtx_d,
   input  wire                        gtx_k,
   output chitchat_pkg::location_t    rx_location,
   output chitchat_pkg::data_t        rx_data0,
   output chitchat_pkg::data_t        rx_data1,
   output chitchat_pkg::data_t        rx_rev_id,
   output chitchat_pkg::frame_count_t rx_frame_counter,
   output chitchat_pkg::frame_count_t rx_loopback_frame_counter,
   output logic                       rx_valid,       // Good frame, fields updated
   output logic                       rx_crc_fault,   // CRC mismatch on word 10
   output logic                       rx_link_up
);

   import chitchat_pkg::*;

   localparam logic [3:0] LAST_WORD  = 4'(CC_FRAME_WORDS - 1);
   localparam int         HOLD_WORDS = CC_FRAME_WORDS - 2;   // Words 1 to 9
   localparam int         CNT_W      = $clog2(LINK_UP_CNT + 1);
   localparam logic [CNT_W-1:0] GOOD_MAX = CNT_W'(LINK_UP_CNT);

   typedef enum logic {
      ST_HUNT,       // Looking for a comma
      ST_RECEIVE     // Locked to frame boundaries
   } state_t;

   state_t     state;
   logic [3:0] word_cnt;     // Index of the word now on gtx_d
   logic       expect_comma;
   logic       is_comma;
   logic       at_crc_word;
   logic       frame_good;
   logic       shift_en;
   word_t      crc_rx;
   word_t      hold_q [1:HOLD_WORDS];
   logic [CNT_W-1:0] good_cnt;   // Saturating run of good frames

   // --------------------------------------------------
   // Word decode
   // --------------------------------------------------

   assign is_comma     = gtx_k && (gtx_d == {CC_PROTOCOL_CAT, CC_PROTOCOL_VER, CC_K28_5});
   assign expect_comma = (state == ST_HUNT) || (word_cnt == '0);
   assign at_crc_word  = (state == ST_RECEIVE) && (word_cnt == LAST_WORD);
   assign frame_good   = at_crc_word && (gtx_d == crc_rx);
   assign shift_en     = (state == ST_RECEIVE) && !expect_comma && !at_crc_word;

   // Held at init until a comma, then folds words 1 to 9
   crc16 crc_i (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (gtx_d),
      .zero   (expect_comma),
      .crc    (crc_rx)
   );

   // --------------------------------------------------
   // Frame FSM and link-up counter
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= ST_HUNT;
         word_cnt     <= '0;
         rx_valid     <= 1'b0;
         rx_crc_fault <= 1'b0;
         good_cnt     <= '0;
         rx_link_up   <= 1'b0;
      end else begin
         rx_valid     <= 1'b0;
         rx_crc_fault <= 1'b0;
         case (state)
            ST_HUNT: begin
               if (is_comma) begin
                  state    <= ST_RECEIVE;
                  word_cnt <= 4'd1;
               end
            end
            ST_RECEIVE: begin
               if (word_cnt == '0) begin
                  if (is_comma) begin
                     word_cnt <= 4'd1;            // Next frame back to back
                  end else begin
                     state      <= ST_HUNT;       // Lost framing
                     good_cnt   <= '0;
                     rx_link_up <= 1'b0;
                  end
               end else if (word_cnt == LAST_WORD) begin
                  word_cnt <= '0;                 // Comma expected next
                  if (frame_good) begin
                     rx_valid <= 1'b1;
                     if (good_cnt != GOOD_MAX) good_cnt <= good_cnt + 1'b1;
                     if (good_cnt >= GOOD_MAX - 1'b1) rx_link_up <= 1'b1;
                  end else begin
                     rx_crc_fault <= 1'b1;
                     good_cnt     <= '0;
                     rx_link_up   <= 1'b0;
                  end
               end else begin
                  word_cnt <= word_cnt + 4'd1;
               end
            end
            default: state <= ST_HUNT;
         endcase
      end
   end

   // --------------------------------------------------
   // Field capture
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (shift_en) begin
         for (int k = 1; k < HOLD_WORDS; k++) begin
            hold_q[k] <= hold_q[k+1];
         end
         hold_q[HOLD_WORDS] <= gtx_d;               // Newest word at the tail
      end
   end

   // Outputs only move on a good frame
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_location               <= '0;
         rx_rev_id                 <= '0;
         rx_data0                  <= '0;
         rx_data1                  <= '0;
         rx_frame_counter          <= '0;           // Looped back as zero until a frame
         rx_loopback_frame_counter <= '0;
      end else if (frame_good) begin
         rx_location               <= hold_q[1][12:10];
         rx_rev_id                 <= {hold_q[2], hold_q[3]};
         rx_data0                  <= {hold_q[4], hold_q[5]};
         rx_data1                  <= {hold_q[6], hold_q[7]};
         rx_frame_counter          <= hold_q[8];
         rx_loopback_frame_counter <= hold_q[9];
      end
   end

endmodule

`default_nettype wire

/* source/chitchat_link.sv */
`timescale 1ns/100ps
`default_nettype none

module chitchat_link #(
   parameter chitchat_pkg::data_t REV_ID      = '0,   // Local gateware revision
   parameter int                  LINK_UP_CNT = 3
) (
   input  wire                             clk,
   input  wire                             arst_n,

   // Transmit side
   input  wire                             tx_transmit_en,
   input  wire chitchat_pkg::location_t    tx_location,
   input  wire chitchat_pkg::data_t        tx_data0,
   input  wire chitchat_pkg::data_t        tx_data1,
   output wire                             tx_ready,
   output wire chitchat_pkg::word_t        tx_gtx_d,
   output wire                             tx_gtx_k,
   output wire chitchat_pkg::frame_count_t local_frame_counter,

   // Receive side
   input  wire chitchat_pkg::word_t        rx_gtx_d,
   input  wire                             rx_gtx_k,
   output wire chitchat_pkg::location_t    rx_location,
   output wire chitchat_pkg::data_t        rx_data0,
   output wire chitchat_pkg::data_t        rx_data1,
   output wire chitchat_pkg::data_t        rx_rev_id,
   output wire chitchat_pkg::frame_count_t rx_frame_counter,
   output wire chitchat_pkg::frame_count_t rx_loopback_frame_counter,
   output wire                             rx_valid,
   output wire                             rx_crc_fault,
   output wire                             rx_link_up
);

   // Far-end counter goes back out in word 9 for round-trip timing
   chitchat_tx #(
      .REV_ID (REV_ID)
   ) tx_i (
      .clk                       (clk),
      .arst_n                    (arst_n),
      .tx_transmit_en            (tx_transmit_en),
      .tx_location               (tx_location),
      .tx_data0                  (tx_data0),
      .tx_data1                  (tx_data1),
      .tx_loopback_frame_counter (rx_frame_counter),
      .tx_ready                  (tx_ready),
      .local_frame_counter       (local_frame_counter),
      .gtx_d                     (tx_gtx_d),
      .gtx_k                     (tx_gtx_k)
   );

   chitchat_rx #(
      .LINK_UP_CNT (LINK_UP_CNT)
   ) rx_i (
      .clk                       (clk),
      .arst_n                    (arst_n),
      .gtx_d                     (rx_gtx_d),
      .gtx_k                     (rx_gtx_k),
      .rx_location               (rx_location),
      .rx_data0                  (rx_data0),
      .rx_data1                  (rx_data1),
      .rx_rev_id                 (rx_rev_id),
      .rx_frame_counter          (rx_frame_counter),
      .rx_loopback_frame_counter (rx_loopback_frame_counter),
      .rx_valid                  (rx_valid),
      .rx_crc_fault              (rx_crc_fault),
      .rx_link_up                (rx_link_up)
   );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter real PERIOD       = 4.0,   // ns
   parameter int  RESET_CYCLES = 8
) (
   output logic clk,
   output logic arst_n
);

   initial clk = 1'b0;
   always #(PERIOD / 2.0) clk = ~clk;

   // Reset held low for a fixed number of rising edges
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb/chitchat_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module chitchat_tb;

   localparam logic [31:0] REV_ID = 32'h1234_5678;
   localparam int          NTESTS = 6;

   wire         clk;
   wire         arst_n;
   logic        tx_transmit_en;
   logic [2:0]  tx_location;
   logic [31:0] tx_data0, tx_data1;
   logic [15:0] rx_gtx_d;
   logic        rx_gtx_k;
   wire         tx_ready, tx_gtx_k, rx_valid, rx_crc_fault, rx_link_up;
   wire  [15:0] tx_gtx_d, local_frame_counter, rx_frame_counter, rx_loopback_frame_counter;
   wire  [2:0]  rx_location;
   wire  [31:0] rx_data0, rx_data1, rx_rev_id;

   tb_clock_gen #(.PERIOD(4.0), .RESET_CYCLES(8)) clk_gen (.clk(clk), .arst_n(arst_n));

   chitchat_link #(.REV_ID(REV_ID), .LINK_UP_CNT(3)) dut (
      .clk(clk), .arst_n(arst_n),
      .tx_transmit_en(tx_transmit_en), .tx_location(tx_location),
      .tx_data0(tx_data0), .tx_data1(tx_data1),
      .tx_ready(tx_ready), .tx_gtx_d(tx_gtx_d), .tx_gtx_k(tx_gtx_k),
      .local_frame_counter(local_frame_counter),
      .rx_gtx_d(rx_gtx_d), .rx_gtx_k(rx_gtx_k),
      .rx_location(rx_location), .rx_data0(rx_data0), .rx_data1(rx_data1),
      .rx_rev_id(rx_rev_id), .rx_frame_counter(rx_frame_counter),
      .rx_loopback_frame_counter(rx_loopback_frame_counter),
      .rx_valid(rx_valid), .rx_crc_fault(rx_crc_fault), .rx_link_up(rx_link_up)
   );

   // --------------------------------------------------
   // Reference model helpers
   // --------------------------------------------------

   // CCITT, MSB first, one word
   function automatic logic [15:0] crc_word(input logic [15:0] c, input logic [15:0] d);
      logic b;
      for (int i = 15; i >= 0; i--) begin
         b = c[15] ^ d[i];
         c = {c[14:0], 1'b0} ^ (b ? 16'h1021 : 16'h0000);
      end
      return c;
   endfunction

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois form
   endfunction

   int          errs [NTESTS];
   int          checks, ready_count, cyc, pos, run, n_vec;
   logic [15:0] lfsr, pat;
   logic        cur_bad, ready_seen, dropped, exp_link, act_bad;
   logic        link_lost, fault_seen, recovered;
   logic [15:0] exp_words[$];
   int          exp_start[$];
   logic        q_txbad[$], q_bad[$];
   logic [2:0]  q_loc[$];
   logic [31:0] q_d0[$], q_d1[$];
   logic [15:0] q_cnt[$], q_lb[$];
   logic [2:0]  last_loc;
   logic [31:0] last_d0, last_d1, last_rev;
   logic [15:0] last_cnt, last_lb;
   logic [2:0]  v_loc[$];
   logic [31:0] v_d0[$], v_d1[$];
   logic        v_bad[$];

   task automatic fail_check(input int t, input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      errs[t]++;
   endtask

   // Frame model, loopback is the last counter the receiver took in
   task automatic build_frame();
      logic [15:0] w [11];
      logic [15:0] c;
      w[0] = {4'd1, 4'd1, 8'hBC};
      w[1] = {3'd2, tx_location, 10'b0};
      w[2] = REV_ID[31:16];
      w[3] = REV_ID[15:0];
      w[4] = tx_data0[31:16];
      w[5] = tx_data0[15:0];
      w[6] = tx_data1[31:16];
      w[7] = tx_data1[15:0];
      w[8] = 16'(ready_count);
      w[9] = last_cnt;
      c = 16'h0000;
      for (int i = 1; i <= 9; i++) c = crc_word(c, w[i]);
      w[10] = c;
      for (int i = 0; i < 11; i++) exp_words.push_back(w[i]);
      exp_start.push_back(cyc + 2);                   // Word 0 seen two edges on
      q_txbad.push_back(cur_bad);
      q_bad.push_back(cur_bad);
      q_loc.push_back(tx_location);
      q_d0.push_back(tx_data0);
      q_d1.push_back(tx_data1);
      q_cnt.push_back(w[8]);
      q_lb.push_back(w[9]);
   endtask

   // --------------------------------------------------
   // Loopback register and monitors
   // --------------------------------------------------

   always @(posedge clk) begin
      if (arst_n) begin
         cyc++;
         rx_gtx_d <= tx_gtx_d;
         rx_gtx_k <= tx_gtx_k;
         if (ready_seen) build_frame();
         ready_seen = tx_ready;
         if (tx_ready) ready_count++;
         if (pos < 0 && exp_start.size() > 0 && cyc == exp_start[0]) begin
            void'(exp_start.pop_front());
            act_bad = q_txbad.pop_front();
            pos     = 0;
         end
         if (pos >= 0) begin
            checks++;
            if (tx_gtx_d !== exp_words[0] || tx_gtx_k !== (pos == 0))
               fail_check(1, $sformatf("word %0d is %h k %b, expected %h", pos,
                                       tx_gtx_d, tx_gtx_k, exp_words[0]));
            void'(exp_words.pop_front());
            if (pos == 5 && act_bad) begin
               pat = 16'h0000;
               for (int i = 0; i < 16; i++) begin
                  lfsr = lfsr_step(lfsr);
                  pat  = {pat[14:0], lfsr[0]};
               end
               if (pat == 16'h0000) pat = 16'h0001;
               rx_gtx_d <= tx_gtx_d ^ pat;            // Corrupt data0 low half
            end
            pos = (pos == 10) ? -1 : pos + 1;
         end else if (tx_gtx_d !== 16'h0000 || tx_gtx_k !== 1'b0) begin
            fail_check(dropped ? 5 : 0, "stream not idle between frames");
         end
         if (link_lost) begin
            exp_link  = 1'b0;                         // Comma missing after the last frame
            run       = 0;
            link_lost = 1'b0;
         end
         if (rx_valid && rx_crc_fault) fail_check(2, "rx_valid and rx_crc_fault together");
         if (rx_valid || rx_crc_fault) begin
            checks++;
            if (pos < 0) link_lost = 1'b1;            // No frame follows this one
            if (q_bad.size() == 0) begin
               fail_check(2, "receiver reported a frame that was never sent");
            end else if (q_bad.pop_front()) begin
               if (!rx_crc_fault) fail_check(4, "corrupted frame not flagged");
               if (rx_location !== last_loc || rx_data0 !== last_d0 ||
                   rx_data1 !== last_d1 || rx_rev_id !== last_rev ||
                   rx_frame_counter !== last_cnt || rx_loopback_frame_counter !== last_lb)
                  fail_check(4, "fields moved on a bad frame");
               run = 0;
               exp_link = 1'b0;
               fault_seen = 1'b1;
               void'(q_loc.pop_front());
               void'(q_d0.pop_front());
               void'(q_d1.pop_front());
               void'(q_cnt.pop_front());
               void'(q_lb.pop_front());
            end else begin
               last_loc = q_loc.pop_front();
               last_d0  = q_d0.pop_front();
               last_d1  = q_d1.pop_front();
               last_cnt = q_cnt.pop_front();
               last_lb  = q_lb.pop_front();
               last_rev = REV_ID;
               if (!rx_valid) fail_check(2, "good frame gave no rx_valid");
               if (rx_location !== last_loc || rx_data0 !== last_d0 ||
                   rx_data1 !== last_d1 || rx_rev_id !== last_rev ||
                   rx_frame_counter !== last_cnt || rx_loopback_frame_counter !== last_lb)
                  fail_check(2, $sformatf("fields wrong, counter %h expected %h",
                                          rx_frame_counter, last_cnt));
               run++;
               if (run >= 3) exp_link = 1'b1;
               if (fault_seen && run == 3 && rx_link_up === 1'b1) recovered = 1'b1;
            end
         end
         if (rx_link_up !== exp_link)
            fail_check(3, $sformatf("rx_link_up %b, expected %b", rx_link_up, exp_link));
      end
   end

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------

   initial begin
      int          fd, t, total, failed;
      string       line;
      logic [31:0] a, b, c, d;
      string       names [NTESTS] = '{"reset and idle", "frame format", "reception",
                                       "link-up", "CRC fault", "enable drop"};
      tx_transmit_en = 1'b0;
      tx_location = '0;
      tx_data0 = '0;
      tx_data1 = '0;
      rx_gtx_d = '0;
      rx_gtx_k = 1'b0;
      cur_bad = 1'b0;
      ready_seen = 1'b0;
      dropped = 1'b0;
      exp_link = 1'b0;
      act_bad = 1'b0;
      link_lost = 1'b0;
      fault_seen = 1'b0;
      recovered = 1'b0;
      checks = 0;
      ready_count = 0;
      cyc = 0;
      pos = -1;
      run = 0;
      lfsr = 16'd56;
      last_loc = '0;
      last_d0 = '0;
      last_d1 = '0;
      last_cnt = '0;
      last_lb = '0;
      last_rev = '0;
      foreach (errs[i]) errs[i] = 0;
      fd = $fopen("tb/chitchat_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file");
         $display("TEST FAILED");
         $finish;
      end
      while (!$feof(fd)) begin
         if ($fgets(line, fd) > 0 && line.getc(0) != 8'h23) begin
            if ($sscanf(line, "%h %h %h %h", a, b, c, d) == 4) begin
               v_loc.push_back(a[2:0]);
               v_d0.push_back(b);
               v_d1.push_back(c);
               v_bad.push_back(d[0]);
            end
         end
      end
      $fclose(fd);
      n_vec = v_loc.size();
      t = 0;
      while (!arst_n && t < 100) begin
         @(posedge clk);
         t++;
      end
      if (!arst_n) begin
         $display("Timed out waiting for reset release");
         $display("TEST FAILED");
         $finish;
      end
      // Idle window, nothing should move
      for (int i = 0; i < 20; i++) begin
         @(posedge clk);
         checks++;
         if (tx_gtx_d !== 0 || tx_gtx_k || tx_ready || rx_valid || rx_crc_fault || rx_link_up)
            fail_check(0, "outputs active while idle");
      end
      $display("test %-16s %s", names[0], errs[0] == 0 ? "passed" : "failed");
      tx_transmit_en <= 1'b1;
      for (int i = 0; i < n_vec; i++) begin
         t = 0;
         do begin
            @(posedge clk);
            t++;
         end while (!tx_ready && t < 40);
         if (!tx_ready) begin
            $display("Timed out waiting for tx_ready");
            $display("TEST FAILED");
            $finish;
         end
         tx_location <= v_loc[i];                     // Loaded on the next edge
         tx_data0    <= v_d0[i];
         tx_data1    <= v_d1[i];
         cur_bad     <= v_bad[i];
      end
      repeat (4) @(posedge clk);
      tx_transmit_en <= 1'b0;                          // Mid-frame release
      dropped = 1'b1;
      t = 0;
      while ((q_bad.size() > 0 || exp_words.size() > 0) && t < 200) begin
         @(posedge clk);
         t++;
      end
      if (q_bad.size() > 0 || exp_words.size() > 0) begin
         $display("Timed out waiting for the last frame to arrive");
         $display("TEST FAILED");
         $finish;
      end
      repeat (30) @(posedge clk);
      checks++;
      if (ready_count != n_vec || local_frame_counter !== 16'(ready_count))
         fail_check(5, $sformatf("%0d ready pulses, counter %0d", ready_count,
                                 local_frame_counter));
      if (!recovered) fail_check(4, "link did not recover after the fault");
      total = 0;
      failed = 0;
      for (int i = 1; i < NTESTS; i++)
         $display("test %-16s %s", names[i], errs[i] == 0 ? "passed" : "failed");
      for (int i = 0; i < NTESTS; i++) begin
         total += errs[i];
         if (errs[i] != 0) failed++;
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d", NTESTS, failed, checks, total);
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/chitchat_vectors.txt */
# Columns, all hex: location data0 data1 corrupt
# corrupt=1 flips bits in word 5 of that frame on the loopback path
1 00000001 a5a5a5a5 0
2 deadbeef 01234567 0
3 cafef00d 89abcdef 0
4 ffffffff 00000000 0
5 13579bdf 2468ace0 0
6 0badc0de 55aa55aa 1
7 11111111 22222222 0
0 33333333 44444444 0
1 80000000 00000001 1
2 7fffffff fffffffe 0
3 c0ffee00 00c0ffee 0
4 600dcafe fee1900d 0

/* all.f */
source/chitchat_pkg.sv
source/crc16.sv
source/chitchat_tx.sv
source/chitchat_rx.sv
source/chitchat_link.sv
tb/tb_clock_gen.sv
tb/chitchat_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Chitchat testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module chitchat_tb -o chitchat_sim

./obj_dir/chitchat_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
